//--- list.f
+incdir+verification
source/mixer_pkg.sv
source/pixel_counter.sv
source/pixel_packer.sv
source/line_fifo.sv
source/port_arbiter.sv
source/burst_writer.sv
source/mixer_top.sv
verification/tb_mixer.sv

//--- source/burst_writer.sv
`timescale 1ns/10ps
`default_nettype none

module burst_writer #(
	parameter int LINE_PIXELS = 1024,
	parameter int FRAME_LINES = 1080
) (
	input  wire                      pclk0,
	input  wire                      vrst,
	input  wire mixer_pkg::grant_t   grant,
	input  wire mixer_pkg::fifo_entry_t entry0,
	input  wire mixer_pkg::fifo_entry_t entry1,
	output logic                     pop0,
	output logic                     pop1,
	output mixer_pkg::mem_wr_t       mem_wr,
	input  wire                      mem_wr_full,
	output mixer_pkg::mem_cmd_t      mem_cmd,
	input  wire                      mem_cmd_full,
	output logic                     burst_done
);

	import mixer_pkg::*;

	localparam int PIXEL_BYTES = $bits(pixel_t) / 8;
	localparam logic [29:0] LINE_BYTES = 30'(LINE_PIXELS * PIXEL_BYTES);
	localparam logic [29:0] PORT_BYTES = 30'(FRAME_LINES * LINE_PIXELS * PIXEL_BYTES);
	localparam logic [29:0] SEG_BYTES  = 30'(BURST_WORDS * WORD_BYTES);
	localparam logic [6:0]  LAST_WORD  = 7'(BURST_WORDS - 1);

	wr_phase_t   phase;
	fifo_entry_t entry;
	logic [6:0]  pop_cnt;    // Words read from the FIFO
	logic [6:0]  acc_cnt;    // Words taken by the controller
	logic        wr_valid;
	logic        pop;
	logic        accept;
	logic [29:0] first_addr;
	logic [29:0] byte_addr;

	assign entry  = (grant == GRANT_PORT1) ? entry1 : entry0;
	assign pop    = (phase == PHASE_DATA) && (pop_cnt < 7'(BURST_WORDS)) && !mem_wr_full;
	assign pop0   = pop && (grant == GRANT_PORT0);
	assign pop1   = pop && (grant == GRANT_PORT1);
	assign accept = wr_valid && !mem_wr_full;

	assign first_addr = ((grant == GRANT_PORT1) ? PORT_BYTES : 30'd0)
		+ 30'(entry.tag.line) * LINE_BYTES
		+ 30'(entry.tag.segment) * SEG_BYTES;

	assign burst_done = (phase == PHASE_CMD) && !mem_cmd_full;

	always_comb begin
		mem_wr      = '0;             // No byte masked
		mem_wr.en   = wr_valid;
		mem_wr.data = entry.word;     // FIFO output holds until the next pop

		mem_cmd           = '0;
		mem_cmd.en        = (phase == PHASE_CMD);
		mem_cmd.op        = MEM_OP_WRITE;
		mem_cmd.bl        = 6'(BURST_WORDS - 1);
		mem_cmd.byte_addr = byte_addr;
	end

	always_ff @(posedge pclk0) begin
		if (vrst) begin
			phase    <= PHASE_IDLE;
			pop_cnt  <= '0;
			acc_cnt  <= '0;
			wr_valid <= 1'b0;
		end else begin
			case (phase)
				PHASE_IDLE: begin
					pop_cnt <= '0;
					acc_cnt <= '0;
					if (grant != GRANT_NONE)
						phase <= PHASE_DATA;
				end
				PHASE_DATA: begin
					// One word in flight, refilled as it is taken
					if (pop) begin
						pop_cnt  <= pop_cnt + 7'd1;
						wr_valid <= 1'b1;
					end else if (accept) begin
						wr_valid <= 1'b0;
					end
					if (accept) begin
						acc_cnt <= acc_cnt + 7'd1;
						if (acc_cnt == LAST_WORD)
							phase <= PHASE_CMD;
					end
				end
				PHASE_CMD: begin
					if (!mem_cmd_full)
						phase <= PHASE_IDLE;
				end
				default: phase <= PHASE_IDLE;
			endcase
		end
	end

	// Burst address from the first word's tag
	always_ff @(posedge pclk0) begin
		if (accept && acc_cnt == '0)
			byte_addr <= first_addr;
	end

endmodule

`default_nettype wire

//--- source/line_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module line_fifo #(
	parameter int FIFO_DEPTH = 256    // Power of two
) (
	input  wire                      pclk0,
	input  wire                      vrst,
	input  wire                      push,
	input  wire mixer_pkg::fifo_entry_t entry_in,
	input  wire                      pop,
	output mixer_pkg::fifo_entry_t   entry_out,
	output logic                     empty
);

	import mixer_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);

	fifo_entry_t ram [FIFO_DEPTH];
	logic [AW:0] wr_ptr;    // Extra bit tells wrap from empty
	logic [AW:0] rd_ptr;
	logic        rd_en;

	assign empty = wr_ptr == rd_ptr;
	assign rd_en = pop && !empty;

	always_ff @(posedge pclk0) begin
		if (push)
			ram[wr_ptr[AW-1:0]] <= entry_in;
		if (rd_en)
			entry_out <= ram[rd_ptr[AW-1:0]];   // Valid the cycle after pop
	end

	always_ff @(posedge pclk0) begin
		if (vrst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/mixer_pkg.sv
`default_nettype none

package mixer_pkg;

	localparam int PIXELS_PER_WORD = 8;
	localparam int BURST_WORDS     = 64;   // 512 pixels per segment
	localparam int WORD_BYTES      = 16;

	typedef logic [15:0]  pixel_t;         // 6-5-5, green on top
	typedef logic [127:0] mem_word_t;

	typedef struct packed {
		logic       hs;
		logic       vs;
		logic       de;
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} video_in_t;

	typedef struct packed {
		logic [1:0]  segment;
		logic [11:0] line;
	} word_tag_t;

	typedef struct packed {
		word_tag_t tag;
		mem_word_t word;
	} fifo_entry_t;

	// Controller instruction encoding
	typedef enum logic [2:0] {
		MEM_OP_WRITE = 3'b000
	} mem_op_t;

	typedef struct packed {
		logic        en;
		mem_op_t     op;
		logic [5:0]  bl;          // Burst length minus one
		logic [29:0] byte_addr;
	} mem_cmd_t;

	typedef struct packed {
		logic        en;
		logic [15:0] mask;        // Set bit masks that byte
		mem_word_t   data;
	} mem_wr_t;

	typedef enum logic [1:0] {
		GRANT_NONE,
		GRANT_PORT0,
		GRANT_PORT1
	} grant_t;

	typedef enum logic [1:0] {
		PHASE_IDLE,
		PHASE_DATA,
		PHASE_CMD
	} wr_phase_t;

endpackage

`default_nettype wire

//--- source/mixer_top.sv
`timescale 1ns/10ps
`default_nettype none

module mixer_top #(
	parameter int LINE_PIXELS = 1024,   // Multiple of 512, at most 2048
	parameter int FRAME_LINES = 1080,
	parameter int FIFO_DEPTH  = 256
) (
	input  wire                    pclk0,
	input  wire                    vrst,
	input  wire mixer_pkg::video_in_t video0,
	input  wire mixer_pkg::video_in_t video1,
	output mixer_pkg::mem_wr_t     mem_wr,
	input  wire                    mem_wr_full,
	output mixer_pkg::mem_cmd_t    mem_cmd,
	input  wire                    mem_cmd_full
);

	import mixer_pkg::*;

	logic [11:0] pixel_count0;
	logic [11:0] pixel_count1;
	logic [11:0] line_count0;
	logic [11:0] line_count1;
	fifo_entry_t push_entry0;
	fifo_entry_t push_entry1;
	fifo_entry_t pop_entry0;
	fifo_entry_t pop_entry1;
	logic        push0;
	logic        push1;
	logic        pop0;
	logic        pop1;
	logic        seg_ready0;
	logic        seg_ready1;
	logic        burst_done;
	grant_t      grant;

	// Port 0 capture
	pixel_counter u_count0 (
		.pclk0      (pclk0),
		.vrst       (vrst),
		.video      (video0),
		.pixel_count(pixel_count0),
		.line_count (line_count0)
	);

	pixel_packer #(.LINE_PIXELS(LINE_PIXELS)) u_pack0 (
		.pclk0      (pclk0),
		.vrst       (vrst),
		.video      (video0),
		.pixel_count(pixel_count0),
		.line_count (line_count0),
		.entry      (push_entry0),
		.push       (push0),
		.seg_ready  (seg_ready0)
	);

	line_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo0 (
		.pclk0    (pclk0),
		.vrst     (vrst),
		.push     (push0),
		.entry_in (push_entry0),
		.pop      (pop0),
		.entry_out(pop_entry0),
		.empty    ()
	);

	// Port 1 capture
	pixel_counter u_count1 (
		.pclk0      (pclk0),
		.vrst       (vrst),
		.video      (video1),
		.pixel_count(pixel_count1),
		.line_count (line_count1)
	);

	pixel_packer #(.LINE_PIXELS(LINE_PIXELS)) u_pack1 (
		.pclk0      (pclk0),
		.vrst       (vrst),
		.video      (video1),
		.pixel_count(pixel_count1),
		.line_count (line_count1),
		.entry      (push_entry1),
		.push       (push1),
		.seg_ready  (seg_ready1)
	);

	line_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo1 (
		.pclk0    (pclk0),
		.vrst     (vrst),
		.push     (push1),
		.entry_in (push_entry1),
		.pop      (pop1),
		.entry_out(pop_entry1),
		.empty    ()
	);

	port_arbiter u_arb (
		.pclk0     (pclk0),
		.vrst      (vrst),
		.seg_ready0(seg_ready0),
		.seg_ready1(seg_ready1),
		.burst_done(burst_done),
		.grant     (grant)
	);

	burst_writer #(
		.LINE_PIXELS(LINE_PIXELS),
		.FRAME_LINES(FRAME_LINES)
	) u_writer (
		.pclk0       (pclk0),
		.vrst        (vrst),
		.grant       (grant),
		.entry0      (pop_entry0),
		.entry1      (pop_entry1),
		.pop0        (pop0),
		.pop1        (pop1),
		.mem_wr      (mem_wr),
		.mem_wr_full (mem_wr_full),
		.mem_cmd     (mem_cmd),
		.mem_cmd_full(mem_cmd_full),
		.burst_done  (burst_done)
	);

endmodule

`default_nettype wire

//--- source/pixel_counter.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_counter (
	input  wire                  pclk0,
	input  wire                  vrst,
	input  wire mixer_pkg::video_in_t video,
	output logic [11:0]          pixel_count,
	output logic [11:0]          line_count
);

	logic vs_q;
	logic de_q;

	always_ff @(posedge pclk0) begin
		if (vrst) begin
			vs_q        <= 1'b0;
			de_q        <= 1'b0;
			pixel_count <= '0;
			line_count  <= '0;
		end else begin
			vs_q <= video.vs;
			de_q <= video.de;

			if (video.de) begin
				if (!de_q)
					pixel_count <= '0;                   // First pixel of the line
				else if (pixel_count != '1)
					pixel_count <= pixel_count + 12'd1;  // Saturate on very long lines
			end

			// New frame restarts the line numbering
			if (video.vs && !vs_q)
				line_count <= '0;
			else if (de_q && !video.de)
				line_count <= line_count + 12'd1;
		end
	end

endmodule

`default_nettype wire

//--- source/pixel_packer.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_packer #(
	parameter int LINE_PIXELS = 1024
) (
	input  wire                    pclk0,
	input  wire                    vrst,
	input  wire mixer_pkg::video_in_t video,
	input  wire [11:0]             pixel_count,
	input  wire [11:0]             line_count,
	output mixer_pkg::fifo_entry_t entry,
	output logic                   push,
	output logic                   seg_ready
);

	import mixer_pkg::*;

	localparam int SEG_PIXELS = PIXELS_PER_WORD * BURST_WORDS;
	localparam int PIXEL_W    = $bits(pixel_t);
	localparam int WORD_W     = $bits(mem_word_t);

	pixel_t    pixel;
	mem_word_t shift_word;
	logic      valid_q;     // Counts belong to a real pixel
	logic      word_end;
	logic      seg_end;
	logic      in_line;
	logic      take;

	assign pixel = {video.green[7:2], video.red[7:3], video.blue[7:3]};

	assign word_end = (pixel_count % PIXELS_PER_WORD) == PIXELS_PER_WORD - 1;
	assign seg_end  = (pixel_count % SEG_PIXELS) == SEG_PIXELS - 1;
	assign in_line  = pixel_count < LINE_PIXELS;
	assign take     = valid_q && word_end;

	// Newest pixel enters at the top, so the first ends up lowest
	always_ff @(posedge pclk0) begin
		if (video.de)
			shift_word <= {pixel, shift_word[WORD_W-1:PIXEL_W]};
	end

	always_ff @(posedge pclk0) begin
		if (vrst) begin
			valid_q   <= 1'b0;
			push      <= 1'b0;
			seg_ready <= 1'b0;
		end else begin
			valid_q   <= video.de;
			push      <= take && in_line;
			seg_ready <= take && in_line && seg_end;
		end
	end

	always_ff @(posedge pclk0) begin
		if (take) begin
			entry.word        <= shift_word;
			entry.tag.segment <= 2'(pixel_count / SEG_PIXELS);
			entry.tag.line    <= line_count;
		end
	end

endmodule

`default_nettype wire

//--- source/port_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module port_arbiter (
	input  wire               pclk0,
	input  wire               vrst,
	input  wire               seg_ready0,
	input  wire               seg_ready1,
	input  wire               burst_done,
	output mixer_pkg::grant_t grant
);

	import mixer_pkg::*;

	logic [7:0] backlog0;   // Complete segments waiting per port
	logic [7:0] backlog1;
	logic       done0;
	logic       done1;

	function automatic logic [7:0] next_backlog(
		input logic [7:0] count,
		input logic       inc,
		input logic       dec
	);
		logic [7:0] result;
		result = count;
		if (inc && !dec)
			result = count + 8'd1;
		else if (dec && !inc)
			result = count - 8'd1;
		return result;
	endfunction

	assign done0 = burst_done && (grant == GRANT_PORT0);
	assign done1 = burst_done && (grant == GRANT_PORT1);

	always_ff @(posedge pclk0) begin
		if (vrst) begin
			backlog0 <= '0;
			backlog1 <= '0;
		end else begin
			backlog0 <= next_backlog(backlog0, seg_ready0, done0);
			backlog1 <= next_backlog(backlog1, seg_ready1, done1);
		end
	end

	// Deeper backlog wins, port 0 on a tie
	always_ff @(posedge pclk0) begin
		if (vrst) begin
			grant <= GRANT_NONE;
		end else begin
			case (grant)
				GRANT_NONE: begin
					if (backlog1 > backlog0)
						grant <= GRANT_PORT1;
					else if (backlog0 != '0)
						grant <= GRANT_PORT0;
					else if (backlog1 != '0)
						grant <= GRANT_PORT1;
				end
				GRANT_PORT0,
				GRANT_PORT1: begin
					if (burst_done)
						grant <= GRANT_NONE;
				end
				default: grant <= GRANT_NONE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verification/tb_mixer_tasks.svh
`ifndef TB_MIXER_TASKS_SVH
`define TB_MIXER_TASKS_SVH

	task automatic start_test(input string name);
		cur_test  = name;
		test_errs = err_count;
		tests_run++;
	endtask

	task automatic finish_test;
		if (err_count == test_errs) begin
			$display("%s passed", cur_test);
		end else begin
			tests_failed++;
			$display("Fail %s: %0d checks failed", cur_test, err_count - test_errs);
		end
	endtask

	task automatic send_vsync(input logic [1:0] ports);
		@(posedge pclk0);
		video0.vs <= ports[0];
		video1.vs <= ports[1];
		repeat (2) @(posedge pclk0);
		video0.vs <= 1'b0;
		video1.vs <= 1'b0;
		repeat (4) @(posedge pclk0);
		for (int p = 0; p < 2; p++) begin
			if (ports[p])
				model_line[p] = 0;
		end
	endtask

	// Both ports share the timing, each gets its own pixels
	task automatic send_line(input logic [1:0] ports, input int npix);
		video_in_t v [2];
		for (int i = 0; i < npix; i++) begin
			for (int p = 0; p < 2; p++) begin
				v[p] = '0;
				if (ports[p]) begin
					pix_state  = xorshift(pix_state);
					v[p].de    = 1'b1;
					v[p].red   = pix_state[7:0];
					v[p].green = pix_state[15:8];
					v[p].blue  = pix_state[23:16];
					model_pixel(p, i, v[p]);
				end
			end
			@(posedge pclk0);
			video0 <= v[0];
			video1 <= v[1];
		end
		@(posedge pclk0);
		video0 <= '0;
		video1 <= '0;
		for (int p = 0; p < 2; p++) begin
			if (ports[p])
				model_line[p]++;
		end
		repeat (BLANK_CYCLES) @(posedge pclk0);
	endtask

	task automatic wait_drained;
		while (burst_port.size() != 0)
			@(posedge pclk0);
		repeat (20) @(posedge pclk0);   // Room for stray words
		assert (exp_word0.size() == 0 && exp_word1.size() == 0) else begin
			$display("Error in %s: expected words were never written", cur_test);
			err_count++;
		end
	endtask

	task automatic expect_bursts(input int start, input int n);
		assert (cmd_count - start == n) else begin
			$display("Fail %s: bursts expected %0d got %0d", cur_test, n, cmd_count - start);
			err_count++;
		end
	endtask

	task automatic reset_quiet;
		start_test("reset");
		repeat (20) begin
			@(negedge pclk0);
			assert (!mem_wr.en && !mem_cmd.en) else begin
				$display("Fail %s: enables expected 00 got %b%b", cur_test, mem_wr.en, mem_cmd.en);
				err_count++;
			end
		end
		finish_test();
	endtask

	task automatic single_segment;
		int start;
		start_test("single_segment");
		start = cmd_count;
		send_vsync(2'b01);
		send_line(2'b01, 512);
		wait_drained();
		expect_bursts(start, 1);
		finish_test();
	endtask

	// Pixels past LINE_PIXELS are dropped
	task automatic line_limit;
		int start;
		start_test("line_limit");
		start = cmd_count;
		send_vsync(2'b10);
		send_line(2'b10, 1100);
		wait_drained();
		expect_bursts(start, 2);
		finish_test();
	endtask

	task automatic both_ports;
		int start;
		start_test("both_ports");
		start = cmd_count;
		send_vsync(2'b11);
		send_line(2'b11, 512);   // Tied backlogs, port 0 first
		wait_drained();
		expect_bursts(start, 2);
		finish_test();
	endtask

	task automatic back_pressure;
		int start;
		start_test("back_pressure");
		start = cmd_count;
		send_vsync(2'b01);
		bp_on <= 1'b1;
		repeat (3) send_line(2'b01, 512);
		wait_drained();
		bp_on <= 1'b0;
		expect_bursts(start, 3);
		finish_test();
	endtask

`endif

//--- verification/tb_mixer.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mixer;

	import mixer_pkg::*;

	localparam int LINE_PIXELS  = 1024;
	localparam int FRAME_LINES  = 1080;
	localparam int FIFO_DEPTH   = 256;
	localparam int BLANK_CYCLES = 16;
	localparam int TOTAL_PIXELS = 512 + 1100 + 512 + 3 * 512;   // Pixel cycles of all tests
	localparam int CYCLE_LIMIT  = 2 * TOTAL_PIXELS + 2000;

	logic        pclk0;
	logic        vrst;
	video_in_t   video0;
	video_in_t   video1;
	mem_wr_t     mem_wr;
	logic        mem_wr_full;
	mem_cmd_t    mem_cmd;
	logic        mem_cmd_full;

	logic [31:0] pix_state;
	logic [31:0] bp_state;
	logic        bp_on;           // Random back-pressure enable
	int          cycle_count;
	int          err_count;
	int          test_errs;
	int          tests_run;
	int          tests_failed;
	int          burst_words;     // Words taken in the current burst
	int          cmd_count;
	string       cur_test;
	mem_word_t   model_word [2];
	int          model_line [2];
	mem_word_t   exp_word0 [$];
	mem_word_t   exp_word1 [$];
	int          burst_port [$];  // Expected burst order
	logic [29:0] burst_addr [$];

	mixer_top #(
		.LINE_PIXELS(LINE_PIXELS),
		.FRAME_LINES(FRAME_LINES),
		.FIFO_DEPTH (FIFO_DEPTH)
	) uut (
		.pclk0       (pclk0),
		.vrst        (vrst),
		.video0      (video0),
		.video1      (video1),
		.mem_wr      (mem_wr),
		.mem_wr_full (mem_wr_full),
		.mem_cmd     (mem_cmd),
		.mem_cmd_full(mem_cmd_full)
	);

	always #2 pclk0 = ~pclk0;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// 6 bits green, 5 red, 5 blue
	function automatic pixel_t reduce_pixel(input video_in_t v);
		return {v.green[7:2], v.red[7:3], v.blue[7:3]};
	endfunction

	function automatic logic [29:0] word_addr(input int port, input int line,
		input int seg);
		return 30'(port * FRAME_LINES * LINE_PIXELS * 2 + line * LINE_PIXELS * 2 + seg * 1024);
	endfunction

	task automatic model_pixel(input int port, input int idx, input video_in_t v);
		model_word[port][16 * (idx % 8) +: 16] = reduce_pixel(v);
		if (idx % 8 == 7 && idx < LINE_PIXELS) begin
			if (port == 0)
				exp_word0.push_back(model_word[port]);
			else
				exp_word1.push_back(model_word[port]);
			if (idx % 512 == 511) begin   // Segment complete
				burst_port.push_back(port);
				burst_addr.push_back(word_addr(port, model_line[port], idx / 512));
			end
		end
	endtask

	task automatic check_word;
		mem_word_t exp;
		logic      ok;
		ok = burst_port.size() != 0 && burst_words < 64;
		assert (ok) else begin
			$display("Error in %s: write data accepted outside an expected burst", cur_test);
			err_count++;
		end
		if (ok) begin
			if (burst_port[0] == 0)
				exp = exp_word0.pop_front();
			else
				exp = exp_word1.pop_front();
			assert (mem_wr.data == exp && mem_wr.mask == '0) else begin
				$display("Fail %s: word %0d expected %h mask 0000 got %h mask %h",
					cur_test, burst_words, exp, mem_wr.data, mem_wr.mask);
				err_count++;
			end
			burst_words++;
		end
	endtask

	task automatic check_cmd;
		logic [29:0] addr;
		int          port;
		logic        ok;
		ok = burst_port.size() != 0;
		assert (ok) else begin
			$display("Error in %s: write command accepted with no burst pending", cur_test);
			err_count++;
		end
		if (ok) begin
			port = burst_port.pop_front();
			addr = burst_addr.pop_front();
			assert (burst_words == 64) else begin
				$display("Fail %s: data words before command expected 64 got %0d",
					cur_test, burst_words);
				err_count++;
			end
			assert (mem_cmd.op == MEM_OP_WRITE && mem_cmd.bl == 6'd63
				&& mem_cmd.byte_addr == addr) else begin
				$display("Fail %s: port %0d command expected op 0 bl 63 addr %h %s",
					cur_test, port, addr, "got");
				$display("    op %0d bl %0d addr %h",
					mem_cmd.op, mem_cmd.bl, mem_cmd.byte_addr);
				err_count++;
			end
			burst_words = 0;
		end
		cmd_count++;
	endtask

	// Outputs are settled at the falling edge
	always @(negedge pclk0) begin
		if (!vrst && mem_wr.en && !mem_wr_full)
			check_word();
		if (!vrst && mem_cmd.en && !mem_cmd_full)
			check_cmd();
	end

	always @(posedge pclk0) begin
		if (bp_on) begin
			bp_state = xorshift(bp_state);
			mem_wr_full  <= bp_state[3];
			mem_cmd_full <= bp_state[9];
		end else begin
			mem_wr_full  <= 1'b0;
			mem_cmd_full <= 1'b0;
		end
	end

	always @(posedge pclk0) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout in %s after %0d cycles, a burst never completed",
				cur_test, cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	`include "tb_mixer_tasks.svh"

	initial begin
		pclk0        = 1'b0;
		vrst         = 1'b1;
		video0       = '0;
		video1       = '0;
		mem_wr_full  = 1'b0;
		mem_cmd_full = 1'b0;
		bp_on        = 1'b0;
		pix_state    = 32'd16;
		bp_state     = 32'd16;
		cycle_count  = 0;
		err_count    = 0;
		test_errs    = 0;
		tests_run    = 0;
		tests_failed = 0;
		burst_words  = 0;
		cmd_count    = 0;
		cur_test     = "startup";
		model_word   = '{default: '0};
		model_line   = '{default: 0};
		repeat (8) @(posedge pclk0);
		vrst <= 1'b0;

		reset_quiet();
		single_segment();
		line_limit();
		both_ports();
		back_pressure();

		$display("Tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, err_count);
		if (err_count == 0 && tests_failed == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
